/* source/itf_pkg.sv */
/*
 * Chip-edge transfer interface definitions
 * Beat widths, FIFO geometry and the transfer-state encoding
 */
package itf_pkg;

    // -------------------------------------------------------------------------
    // Beat payload
    // -------------------------------------------------------------------------

    // One off-chip beat
    localparam int unsigned DAT_W = 128;

    // Configuration-ready bits reported by the CCU
    localparam int unsigned CFG_RDY_W = 5;

    // -------------------------------------------------------------------------
    // FIFO geometry and entry layout
    // -------------------------------------------------------------------------

    // 16 entries per direction
    localparam int unsigned FIFO_ADDR_W = 4;

    // Payload on top, then flag, then last
    localparam int unsigned FIFO_W = DAT_W + 2;

    // ISA flag inbound, CMD flag outbound
    localparam int unsigned FLAG_BIT = 1;
    localparam int unsigned LAST_BIT = 0;

    // -------------------------------------------------------------------------
    // Transfer direction shared by both port FSMs
    // -------------------------------------------------------------------------
    typedef enum logic [1:0] {
        XFER_IDLE    = 2'd0,
        XFER_IN2CHIP = 2'd1,
        XFER_OUT2OFF = 2'd2
    } xfer_state_e;

endpackage

/* source/sync_fifo_fwft.sv */
/*
 * Single-clock first-word-fall-through FIFO
 * The oldest entry is always visible on the output while not empty
 */
`timescale 1ns/1ps

module sync_fifo_fwft #(
    parameter int unsigned WIDTH  = 8,
    parameter int unsigned ADDR_W = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] din_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o
);

    // Entry storage
    logic [WIDTH-1:0] mem [0:(1 << ADDR_W)-1];

    // Extra MSB tells a wrapped writer from an equal reader
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    // -------------------------------------------------------------------------
    // Pointers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Data array
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr[ADDR_W-1:0]] <= din_i;
        end
    end

    // Head of queue falls through combinationally
    assign dout_o = mem[rd_ptr[ADDR_W-1:0]];

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // -------------------------------------------------------------------------
    // Protocol checks on the caller
    // -------------------------------------------------------------------------
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
    ) else $error("push into full FIFO");

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
    ) else $error("pop from empty FIFO");

endmodule

/* source/offchip_port_ctrl.sv */
/*
 * Off-chip side controller
 * Accepts inbound bursts into the in-FIFO and drains the out-FIFO off chip
 */
`timescale 1ns/1ps

module offchip_port_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        byp_oe_i,
    input  logic                        off_oe_i,
    input  logic                        off_vld_i,
    input  logic                        off_last_i,
    input  logic                        off_isa_i,
    input  logic                        off_rdy_i,
    input  logic [itf_pkg::DAT_W-1:0]   off_dat_i,
    input  logic                        in_full_i,
    input  logic                        out_empty_i,
    input  logic [itf_pkg::FIFO_W-1:0]  out_dout_i,
    output logic                        off_rdy_o,
    output logic                        off_vld_o,
    output logic                        off_last_o,
    output logic                        off_cmd_o,
    output logic                        off_oe_o,
    output logic [itf_pkg::DAT_W-1:0]   off_dat_o,
    output logic                        in_push_o,
    output logic [itf_pkg::FIFO_W-1:0]  in_din_o,
    output logic                        out_pop_o
);

    import itf_pkg::*;

    xfer_state_e state_q;
    xfer_state_e state_d;
    logic        in2chip;
    logic        out2off;

    assign in2chip = (state_q == XFER_IN2CHIP);
    assign out2off = (state_q == XFER_OUT2OFF);

    // -------------------------------------------------------------------------
    // FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            XFER_IDLE: begin
                // Inbound wins over a pending outbound burst
                if (off_vld_i) begin
                    state_d = XFER_IN2CHIP;
                end else if (!out_empty_i) begin
                    state_d = XFER_OUT2OFF;
                end
            end
            XFER_IN2CHIP: begin
                if (in_push_o && off_last_i) begin
                    state_d = XFER_IDLE;
                end
            end
            XFER_OUT2OFF: begin
                if (out_pop_o && off_last_o) begin
                    state_d = XFER_IDLE;
                end
            end
            default: state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= XFER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // -------------------------------------------------------------------------
    // Inbound beat packing with ISA flag and last
    // -------------------------------------------------------------------------
    assign off_rdy_o = in2chip && !in_full_i;
    assign in_push_o = off_vld_i && off_rdy_o;
    assign in_din_o  = {off_dat_i, off_isa_i, off_last_i};

    // -------------------------------------------------------------------------
    // Outbound head presentation from the out-FIFO
    // -------------------------------------------------------------------------
    assign off_vld_o  = out2off && !out_empty_i;
    assign off_dat_o  = out2off ? out_dout_i[FIFO_W-1 -: DAT_W] : '0;
    assign off_cmd_o  = out2off && out_dout_i[FLAG_BIT];
    assign off_last_o = out2off && out_dout_i[LAST_BIT];
    assign out_pop_o  = off_vld_o && off_rdy_i;

    // Strap override wins over drive while sending
    assign off_oe_o = byp_oe_i ? off_oe_i : off_vld_o;

    // Outbound head holds until taken
    a_off_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        off_vld_o && !off_rdy_i |=>
            off_vld_o && $stable(off_dat_o) && $stable(off_last_o) && $stable(off_cmd_o)
    ) else $error("outbound beat changed before its handshake");

endmodule

/* source/core_port_ctrl.sv */
/*
 * Core side controller
 * Routes inbound beats to CCU or GIC and merges monitor/GIC beats outbound
 */
`timescale 1ns/1ps

module core_port_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [itf_pkg::FIFO_W-1:0]    in_dout_i,
    input  logic                          in_empty_i,
    input  logic                          out_full_i,
    input  logic                          ccu_rdy_i,
    input  logic                          gic_out_rdy_i,
    input  logic [itf_pkg::DAT_W-1:0]     mon_dat_i,
    input  logic [itf_pkg::DAT_W-1:0]     gic_in_dat_i,
    input  logic                          mon_vld_i,
    input  logic                          mon_last_i,
    input  logic                          gic_in_vld_i,
    input  logic                          gic_in_last_i,
    input  logic                          gic_in_cmd_i,
    input  logic [itf_pkg::CFG_RDY_W-1:0] ccu_cfg_rdy_i,
    output logic                          in_pop_o,
    output logic                          out_push_o,
    output logic [itf_pkg::FIFO_W-1:0]    out_din_o,
    output logic [itf_pkg::DAT_W-1:0]     ccu_dat_o,
    output logic [itf_pkg::DAT_W-1:0]     gic_out_dat_o,
    output logic                          ccu_vld_o,
    output logic                          ccu_last_o,
    output logic                          gic_out_vld_o,
    output logic                          gic_out_last_o,
    output logic                          mon_rdy_o,
    output logic                          gic_in_rdy_o,
    output logic [itf_pkg::CFG_RDY_W-1:0] cfg_rdy_o
);

    import itf_pkg::*;

    xfer_state_e        state_q;
    xfer_state_e        state_d;
    logic               in2chip;
    logic               out2off;
    logic [DAT_W-1:0]   head_dat;
    logic               head_isa;
    logic               head_last;
    logic               head_vld;
    logic               mon_hs;
    logic               gic_hs;

    assign in2chip = (state_q == XFER_IN2CHIP);
    assign out2off = (state_q == XFER_OUT2OFF);

    // -------------------------------------------------------------------------
    // FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            XFER_IDLE: begin
                if (!in_empty_i) begin
                    state_d = XFER_IN2CHIP;
                end else if (mon_vld_i || gic_in_vld_i) begin
                    state_d = XFER_OUT2OFF;
                end
            end
            XFER_IN2CHIP: begin
                if (in_pop_o && head_last) begin
                    state_d = XFER_IDLE;
                end
            end
            XFER_OUT2OFF: begin
                if ((mon_hs && mon_last_i) || (gic_hs && gic_in_last_i)) begin
                    state_d = XFER_IDLE;
                end
            end
            default: state_d = XFER_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= XFER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // -------------------------------------------------------------------------
    // Inbound steering of the head entry by ISA flag
    // -------------------------------------------------------------------------
    assign head_dat  = in_dout_i[FIFO_W-1 -: DAT_W];
    assign head_isa  = in_dout_i[FLAG_BIT];
    assign head_last = in_dout_i[LAST_BIT];
    assign head_vld  = in2chip && !in_empty_i;

    assign ccu_vld_o      = head_vld && head_isa;
    assign ccu_last_o     = ccu_vld_o && head_last;
    assign ccu_dat_o      = (in2chip && head_isa) ? head_dat : '0;
    assign gic_out_vld_o  = head_vld && !head_isa;
    assign gic_out_last_o = gic_out_vld_o && head_last;
    assign gic_out_dat_o  = (in2chip && !head_isa) ? head_dat : '0;

    assign in_pop_o = (ccu_vld_o && ccu_rdy_i) || (gic_out_vld_o && gic_out_rdy_i);

    // -------------------------------------------------------------------------
    // Outbound merge with monitor priority
    // -------------------------------------------------------------------------
    assign mon_rdy_o = out2off && !out_full_i;
    // GIC held off whenever the monitor has a beat up
    assign gic_in_rdy_o = out2off && !out_full_i && !mon_vld_i;

    assign mon_hs     = mon_vld_i && mon_rdy_o;
    assign gic_hs     = gic_in_vld_i && gic_in_rdy_o;
    assign out_push_o = mon_hs || gic_hs;
    assign out_din_o  = mon_vld_i ? {mon_dat_i, 1'b0, mon_last_i}
                                  : {gic_in_dat_i, gic_in_cmd_i, gic_in_last_i};

    // Config-ready delayed by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdy_o <= '0;
        end else begin
            cfg_rdy_o <= ccu_cfg_rdy_i;
        end
    end

    // Inbound head holds until taken
    a_core_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        head_vld && !in_pop_o |=> head_vld && $stable(in_dout_i)
    ) else $error("inbound head changed before its handshake");

endmodule

/* source/chip_itf_top.sv */
/*
 * Chip-edge transfer interface top
 * Off-side and core-side controllers joined by one FIFO per direction
 */
`timescale 1ns/1ps

module chip_itf_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          byp_oe_i,
    input  logic                          off_oe_i,
    input  logic                          off_vld_i,
    input  logic                          off_last_i,
    input  logic                          off_isa_i,
    input  logic [itf_pkg::DAT_W-1:0]     off_dat_i,
    input  logic                          off_rdy_i,
    output logic                          off_rdy_o,
    output logic                          off_vld_o,
    output logic                          off_last_o,
    output logic                          off_cmd_o,
    output logic [itf_pkg::DAT_W-1:0]     off_dat_o,
    output logic                          off_oe_o,
    input  logic                          ccu_rdy_i,
    input  logic [itf_pkg::CFG_RDY_W-1:0] ccu_cfg_rdy_i,
    output logic [itf_pkg::DAT_W-1:0]     ccu_dat_o,
    output logic                          ccu_vld_o,
    output logic                          ccu_last_o,
    output logic [itf_pkg::CFG_RDY_W-1:0] cfg_rdy_o,
    input  logic [itf_pkg::DAT_W-1:0]     gic_in_dat_i,
    input  logic                          gic_in_vld_i,
    input  logic                          gic_in_last_i,
    input  logic                          gic_in_cmd_i,
    output logic                          gic_in_rdy_o,
    output logic [itf_pkg::DAT_W-1:0]     gic_out_dat_o,
    output logic                          gic_out_vld_o,
    output logic                          gic_out_last_o,
    input  logic                          gic_out_rdy_i,
    input  logic [itf_pkg::DAT_W-1:0]     mon_dat_i,
    input  logic                          mon_vld_i,
    input  logic                          mon_last_i,
    output logic                          mon_rdy_o
);

    import itf_pkg::*;

    // Inbound FIFO
    logic              in_push;
    logic              in_pop;
    logic [FIFO_W-1:0] in_din;
    logic [FIFO_W-1:0] in_dout;
    logic              in_empty;
    logic              in_full;

    // Outbound FIFO
    logic              out_push;
    logic              out_pop;
    logic [FIFO_W-1:0] out_din;
    logic [FIFO_W-1:0] out_dout;
    logic              out_empty;
    logic              out_full;

    // -------------------------------------------------------------------------
    // Controllers
    // -------------------------------------------------------------------------
    offchip_port_ctrl u_off_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .byp_oe_i    (byp_oe_i),
        .off_oe_i    (off_oe_i),
        .off_vld_i   (off_vld_i),
        .off_last_i  (off_last_i),
        .off_isa_i   (off_isa_i),
        .off_rdy_i   (off_rdy_i),
        .off_dat_i   (off_dat_i),
        .in_full_i   (in_full),
        .out_empty_i (out_empty),
        .out_dout_i  (out_dout),
        .off_rdy_o   (off_rdy_o),
        .off_vld_o   (off_vld_o),
        .off_last_o  (off_last_o),
        .off_cmd_o   (off_cmd_o),
        .off_oe_o    (off_oe_o),
        .off_dat_o   (off_dat_o),
        .in_push_o   (in_push),
        .in_din_o    (in_din),
        .out_pop_o   (out_pop)
    );

    core_port_ctrl u_core_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_dout_i      (in_dout),
        .in_empty_i     (in_empty),
        .out_full_i     (out_full),
        .ccu_rdy_i      (ccu_rdy_i),
        .gic_out_rdy_i  (gic_out_rdy_i),
        .mon_dat_i      (mon_dat_i),
        .gic_in_dat_i   (gic_in_dat_i),
        .mon_vld_i      (mon_vld_i),
        .mon_last_i     (mon_last_i),
        .gic_in_vld_i   (gic_in_vld_i),
        .gic_in_last_i  (gic_in_last_i),
        .gic_in_cmd_i   (gic_in_cmd_i),
        .ccu_cfg_rdy_i  (ccu_cfg_rdy_i),
        .in_pop_o       (in_pop),
        .out_push_o     (out_push),
        .out_din_o      (out_din),
        .ccu_dat_o      (ccu_dat_o),
        .gic_out_dat_o  (gic_out_dat_o),
        .ccu_vld_o      (ccu_vld_o),
        .ccu_last_o     (ccu_last_o),
        .gic_out_vld_o  (gic_out_vld_o),
        .gic_out_last_o (gic_out_last_o),
        .mon_rdy_o      (mon_rdy_o),
        .gic_in_rdy_o   (gic_in_rdy_o),
        .cfg_rdy_o      (cfg_rdy_o)
    );

    // -------------------------------------------------------------------------
    // Direction FIFOs
    // -------------------------------------------------------------------------
    sync_fifo_fwft #(
        .WIDTH  (FIFO_W),
        .ADDR_W (FIFO_ADDR_W)
    ) u_in_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (in_push),
        .pop_i   (in_pop),
        .din_i   (in_din),
        .dout_o  (in_dout),
        .empty_o (in_empty),
        .full_o  (in_full)
    );

    sync_fifo_fwft #(
        .WIDTH  (FIFO_W),
        .ADDR_W (FIFO_ADDR_W)
    ) u_out_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (out_push),
        .pop_i   (out_pop),
        .din_i   (out_din),
        .dout_o  (out_dout),
        .empty_o (out_empty),
        .full_o  (out_full)
    );

endmodule

/* test/tb_chip_itf_tasks.svh */
/*
 * Testbench helpers for the chip-edge transfer interface
 * Value check, cycle stepping, LCG and the directed burst tests
 */

// ---------------------------------------------------------------------------
// Basic helpers
// ---------------------------------------------------------------------------

task automatic check_val(input string name, input logic [DAT_W-1:0] got,
                         input logic [DAT_W-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

// Drive point 1 ns after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [DAT_W-1:0] rand_beat();
    logic [DAT_W-1:0] b = '0;
    for (int i = 0; i < DAT_W / 32; i++) begin
        b = {b[DAT_W-33:0], rand32()};
    end
    return b;
endfunction

// ---------------------------------------------------------------------------
// Directed tests
// ---------------------------------------------------------------------------

task automatic check_reset_state();
    @(negedge clk);
    check_val("off_rdy_o", off_rdy_o, 0);
    check_val("off_vld_o", off_vld_o, 0);
    check_val("ccu_vld_o", ccu_vld_o, 0);
    check_val("gic_out_vld_o", gic_out_vld_o, 0);
    check_val("mon_rdy_o", mon_rdy_o, 0);
    check_val("gic_in_rdy_o", gic_in_rdy_o, 0);
    check_val("off_oe_o", off_oe_o, 0);
    check_val("cfg_rdy_o", cfg_rdy_o, 0);
    next_cycle();
    ccu_cfg_rdy_i = '0;
endtask

// Core ready mode 0 is always high, 1 follows the LCG, 2 stays low until 16 beats are held
task automatic inbound_burst(input int n, input logic isa, input int rdy_mode);
    int               sent = 0;
    int               rcvd = 0;
    int               stall = 0;
    int               cyc = 0;
    logic             rdy;
    logic             got_vld;
    logic             got_last;
    logic             other_vld;
    logic [DAT_W-1:0] got_dat;
    logic [31:0]      r;
    string            pfx;
    string            other;

    if (isa) begin
        pfx   = "ccu";
        other = "gic_out_vld_o";
    end else begin
        pfx   = "gic_out";
        other = "ccu_vld_o";
    end
    for (int i = 0; i < n; i++) begin
        beat_dat[i] = rand_beat();
    end
    off_isa_i = isa;
    while (rcvd < n) begin
        off_vld_i  = (sent < n);
        off_dat_i  = beat_dat[sent];
        off_last_i = (sent == n - 1);
        r = rand32();
        if (rdy_mode == 0) begin
            rdy = 1'b1;
        end else if (rdy_mode == 1) begin
            rdy = r[16];
        end else begin
            rdy = (stall >= 3);
        end
        ccu_rdy_i     = isa && rdy;
        gic_out_rdy_i = !isa && rdy;

        @(negedge clk);
        got_vld   = isa ? ccu_vld_o : gic_out_vld_o;
        got_dat   = isa ? ccu_dat_o : gic_out_dat_o;
        got_last  = isa ? ccu_last_o : gic_out_last_o;
        other_vld = isa ? gic_out_vld_o : ccu_vld_o;
        check_val(other, other_vld, 0);
        // In-FIFO full with 16 beats and none drained
        if (rdy_mode == 2 && sent == 16 && stall < 3) begin
            check_val("off_rdy_o", off_rdy_o, 0);
            stall++;
        end
        if (got_vld && rdy) begin
            check_val({pfx, "_dat_o"}, got_dat, beat_dat[rcvd]);
            check_val({pfx, "_last_o"}, got_last, rcvd == n - 1);
            rcvd++;
        end
        if (off_vld_i && off_rdy_o) begin
            sent++;
        end
        next_cycle();
        cyc++;
        if (cyc > TIMEOUT_CYC) begin
            fail_run($sformatf("Inbound burst stalled with %0d of %0d beats delivered",
                               rcvd, n));
        end
    end
    off_vld_i     = 1'b0;
    off_last_i    = 1'b0;
    ccu_rdy_i     = 1'b0;
    gic_out_rdy_i = 1'b0;
endtask

// Monitor burst first, then the GIC burst, both raised together
task automatic outbound_burst(input int n_mon, input int n_gic, input logic cmd);
    int          mon_sent = 0;
    int          gic_sent = 0;
    int          rcvd = 0;
    int          cyc = 0;
    int          total;
    logic [31:0] r;

    total = n_mon + n_gic;
    for (int i = 0; i < total; i++) begin
        beat_dat[i] = rand_beat();
    end
    while (rcvd < total) begin
        mon_vld_i     = (mon_sent < n_mon);
        mon_dat_i     = beat_dat[mon_sent];
        mon_last_i    = (mon_sent == n_mon - 1);
        gic_in_vld_i  = (gic_sent < n_gic);
        gic_in_dat_i  = beat_dat[n_mon + gic_sent];
        gic_in_last_i = (gic_sent == n_gic - 1);
        gic_in_cmd_i  = cmd;
        r = rand32();
        off_rdy_i = r[16];

        @(negedge clk);
        check_val("off_oe_o", off_oe_o, off_vld_o);
        if (mon_vld_i) begin
            check_val("gic_in_rdy_o", gic_in_rdy_o, 0);
        end
        if (off_vld_o && off_rdy_i) begin
            check_val("off_dat_o", off_dat_o, beat_dat[rcvd]);
            check_val("off_cmd_o", off_cmd_o, (rcvd >= n_mon) && cmd);
            check_val("off_last_o", off_last_o,
                      (rcvd == n_mon - 1) || (rcvd == total - 1));
            rcvd++;
        end
        if (mon_vld_i && mon_rdy_o) begin
            mon_sent++;
        end
        if (gic_in_vld_i && gic_in_rdy_o) begin
            gic_sent++;
        end
        next_cycle();
        cyc++;
        if (cyc > TIMEOUT_CYC) begin
            fail_run($sformatf("Outbound burst stalled with %0d of %0d beats sent off chip",
                               rcvd, total));
        end
    end
    mon_vld_i     = 1'b0;
    mon_last_i    = 1'b0;
    gic_in_vld_i  = 1'b0;
    gic_in_last_i = 1'b0;
    gic_in_cmd_i  = 1'b0;
    off_rdy_i     = 1'b0;
endtask

task automatic cfg_and_oe_override();
    logic [CFG_RDY_W-1:0] prev = '0;
    logic [31:0]          r;

    // Register output trails the input by exactly one edge
    for (int i = 0; i < 8; i++) begin
        r = rand32();
        ccu_cfg_rdy_i = r[20:16];
        @(negedge clk);
        check_val("cfg_rdy_o", cfg_rdy_o, prev);
        prev = ccu_cfg_rdy_i;
        next_cycle();
    end
    @(negedge clk);
    check_val("cfg_rdy_o", cfg_rdy_o, prev);
    next_cycle();

    byp_oe_i = 1'b1;
    for (int i = 0; i < 6; i++) begin
        r = rand32();
        off_oe_i = r[16];
        @(negedge clk);
        check_val("off_oe_o", off_oe_o, off_oe_i);
        next_cycle();
    end
    byp_oe_i = 1'b0;
    off_oe_i = 1'b0;
endtask

/* test/tb_chip_itf.sv */
/*
 * Testbench for the chip-edge transfer interface
 * Clock, reset, DUT instance and the directed test sequence
 */
`timescale 1ns/1ps

module tb_chip_itf;

    import itf_pkg::*;

    // Cycles allowed for any single burst to complete
    localparam int TIMEOUT_CYC = 400;

    logic                 clk;
    logic                 rst_n;
    logic                 byp_oe_i;
    logic                 off_oe_i;
    logic                 off_vld_i;
    logic                 off_last_i;
    logic                 off_isa_i;
    logic [DAT_W-1:0]     off_dat_i;
    logic                 off_rdy_i;
    logic                 off_rdy_o;
    logic                 off_vld_o;
    logic                 off_last_o;
    logic                 off_cmd_o;
    logic [DAT_W-1:0]     off_dat_o;
    logic                 off_oe_o;
    logic                 ccu_rdy_i;
    logic [CFG_RDY_W-1:0] ccu_cfg_rdy_i;
    logic [DAT_W-1:0]     ccu_dat_o;
    logic                 ccu_vld_o;
    logic                 ccu_last_o;
    logic [CFG_RDY_W-1:0] cfg_rdy_o;
    logic [DAT_W-1:0]     gic_in_dat_i;
    logic                 gic_in_vld_i;
    logic                 gic_in_last_i;
    logic                 gic_in_cmd_i;
    logic                 gic_in_rdy_o;
    logic [DAT_W-1:0]     gic_out_dat_o;
    logic                 gic_out_vld_o;
    logic                 gic_out_last_o;
    logic                 gic_out_rdy_i;
    logic [DAT_W-1:0]     mon_dat_i;
    logic                 mon_vld_i;
    logic                 mon_last_i;
    logic                 mon_rdy_o;

    // LCG state and the payloads of the burst in flight
    logic [31:0]          lcg_state;
    logic [DAT_W-1:0]     beat_dat [0:31];

    chip_itf_top UUT (.*);

    // 100 ns clock
    always #50 clk = ~clk;

    // Report the cause, then stop with a failing status
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    `include "tb_chip_itf_tasks.svh"

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        lcg_state     = 32'd88826;
        byp_oe_i      = 1'b0;
        off_oe_i      = 1'b0;
        off_vld_i     = 1'b0;
        off_last_i    = 1'b0;
        off_isa_i     = 1'b0;
        off_dat_i     = '0;
        off_rdy_i     = 1'b0;
        ccu_rdy_i     = 1'b0;
        // Held non-zero through reset
        ccu_cfg_rdy_i = '1;
        gic_in_dat_i  = '0;
        gic_in_vld_i  = 1'b0;
        gic_in_last_i = 1'b0;
        gic_in_cmd_i  = 1'b0;
        gic_out_rdy_i = 1'b0;
        mon_dat_i     = '0;
        mon_vld_i     = 1'b0;
        mon_last_i    = 1'b0;

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_reset_state();
        // GIC inbound, then CCU with random and with stalled ready
        inbound_burst(8, 1'b0, 0);
        inbound_burst(6, 1'b1, 1);
        inbound_burst(20, 1'b1, 2);
        // GIC alone, then monitor racing the GIC
        outbound_burst(0, 5, 1'b1);
        outbound_burst(3, 4, 1'b1);
        cfg_and_oe_override();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+test
source/itf_pkg.sv
source/sync_fifo_fwft.sv
source/offchip_port_ctrl.sv
source/core_port_ctrl.sv
source/chip_itf_top.sv
test/tb_chip_itf.sv

/* Makefile */
# Verilator simulation of the chip-edge transfer interface
# The run exits non-zero when the testbench reports a failure

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_chip_itf -Mdir obj_dir
	./obj_dir/Vtb_chip_itf

clean:
	rm -rf obj_dir
